//--- hw/capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// sample width from the ADC
`define CAP_SAMPLE_W            12
`define CAP_SAMPLES_PER_WORD    3

// sample counters, presample_i and max_samples_i
`define CAP_COUNT_W             16
`define CAP_DECIM_W             8

// presample_i must stay below the sample FIFO depth
`define CAP_SAMPLE_FIFO_DEPTH   32
`define CAP_WORD_FIFO_DEPTH     16

`endif

//--- hw/capture_pkg.sv
`default_nettype none

`include "capture_config.svh"

package capture_pkg;

    typedef logic [`CAP_SAMPLE_W-1:0] sample_t;

    // packer view: oldest sample in the top bits
    // hi-res view: four whole bytes then the trailing nibble
    typedef union packed {
        sample_t [`CAP_SAMPLES_PER_WORD-1:0] samples;
        struct packed {
            logic [3:0][7:0] bytes;
            logic [3:0]      nibble;
        } hires;
    } capture_word_u;

    localparam int unsigned err_overflow_bit = 0;  // sample FIFO was full on a write
    localparam int unsigned err_presamp_bit  = 1;  // trigger before presamples were full
    localparam int unsigned err_config_bit   = 2;  // decimation together with presampling

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 32
) (
    input  wire              adc_sampleclk,
    input  wire              reset,
    input  wire              wr_valid_i,
    input  wire [WIDTH-1:0]  wr_data_i,
    output logic             wr_ready_o,
    output logic             rd_valid_o,
    output logic [WIDTH-1:0] rd_data_o,
    input  wire              rd_ready_i
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             push;
    logic             pop;

    assign wr_ready_o = (fill != CNT_W'(DEPTH));
    assign rd_valid_o = (fill != '0);
    assign rd_data_o  = mem[rd_ptr];  // head of queue, no output register
    assign push       = wr_valid_i && wr_ready_o;
    assign pop        = rd_valid_o && rd_ready_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (push)
            mem[wr_ptr] <= wr_data_i;
    end

endmodule

`default_nettype wire

//--- hw/capture_ctrl.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module capture_ctrl
    import capture_pkg::*;
(
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    input  wire                    arm_i,
    input  wire                    trigger_i,
    input  wire [`CAP_COUNT_W-1:0] presample_i,
    input  wire [`CAP_COUNT_W-1:0] max_samples_i,
    input  wire [`CAP_DECIM_W-1:0] downsample_i,
    input  wire sample_t           adc_datain_i,
    input  wire                    sample_fifo_ready_i,
    input  wire                    sample_fifo_valid_i,
    output logic                   sample_wr_o,
    output sample_t                sample_data_o,
    output logic                   drain_o,
    output logic                   forward_en_o,
    output logic                   capture_done_o,
    output logic [2:0]             error_stat_o
);
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_FILLING   = 3'd1;
    localparam logic [2:0] ST_FULL      = 3'd2;
    localparam logic [2:0] ST_TRIGGERED = 3'd3;
    localparam logic [2:0] ST_DONE      = 3'd4;

    logic [2:0]              state;
    logic [`CAP_DECIM_W-1:0] decim_cnt;
    logic                    eligible;
    logic                    writing;
    logic                    wr_ok;
    logic                    count_inc;
    logic [`CAP_COUNT_W-1:0] sample_cnt;
    logic [`CAP_COUNT_W-1:0] cnt_nxt;
    logic [1:0]              mod3;      // sample_cnt modulo 3
    logic [1:0]              mod_nxt;
    logic                    reached;
    logic [2:0]              err;
    logic                    done_q;

    // one eligible clock in every downsample_i+1
    assign eligible = (decim_cnt >= downsample_i);

    // with no presamples the full state just waits for the trigger
    assign writing = (state == ST_FILLING) || (state == ST_TRIGGERED) ||
                     ((state == ST_FULL) && (presample_i != '0));

    assign sample_wr_o   = eligible && writing;
    assign sample_data_o = adc_datain_i;
    assign wr_ok         = sample_wr_o && sample_fifo_ready_i;
    assign drain_o       = (state == ST_FULL) && wr_ok;  // keeps the history at presample_i
    assign forward_en_o  = (state == ST_TRIGGERED) || (state == ST_DONE);

    assign count_inc = wr_ok && ((state == ST_FILLING) || (state == ST_TRIGGERED));
    assign cnt_nxt   = sample_cnt + `CAP_COUNT_W'(count_inc);
    assign mod_nxt   = !count_inc ? mod3 : (mod3 == 2'd2) ? 2'd0 : mod3 + 2'd1;
    assign reached   = (cnt_nxt >= max_samples_i) && (mod_nxt == 2'd0);

    assign capture_done_o = done_q;
    assign error_stat_o   = err;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            decim_cnt <= '0;
        end else if (arm_i || eligible) begin
            decim_cnt <= '0;
        end else begin
            decim_cnt <= decim_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state      <= ST_IDLE;
            sample_cnt <= '0;
            mod3       <= 2'd0;
            err        <= '0;
            done_q     <= 1'b0;
        end else if (arm_i) begin
            state      <= (presample_i != '0) ? ST_FILLING : ST_FULL;
            sample_cnt <= '0;
            mod3       <= 2'd0;
            done_q     <= 1'b0;
            err        <= '0;
            err[err_config_bit] <= (downsample_i != '0) && (presample_i != '0);
        end else begin
            sample_cnt <= cnt_nxt;
            mod3       <= mod_nxt;
            if (sample_wr_o && !sample_fifo_ready_i)
                err[err_overflow_bit] <= 1'b1;  // write dropped

            case (state)
                ST_FILLING: begin
                    if (trigger_i) begin
                        if (cnt_nxt < presample_i)
                            err[err_presamp_bit] <= 1'b1;
                        state <= reached ? ST_DONE : ST_TRIGGERED;
                    end else if (count_inc && (cnt_nxt == presample_i)) begin
                        state <= ST_FULL;
                    end
                end
                ST_FULL: begin
                    if (trigger_i)
                        state <= reached ? ST_DONE : ST_TRIGGERED;
                end
                ST_TRIGGERED: begin
                    if (reached)
                        state <= ST_DONE;
                end
                ST_DONE: begin
                    // packer has taken every sample once the FIFO runs dry
                    if (!sample_fifo_valid_i)
                        done_q <= 1'b1;
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/word_packer.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module word_packer
    import capture_pkg::*;
(
    input  wire            adc_sampleclk,
    input  wire            reset,
    input  wire            sample_valid_i,
    input  wire sample_t   sample_data_i,
    output logic           sample_ready_o,
    input  wire            drain_i,
    input  wire            forward_en_i,
    output logic           word_valid_o,
    output capture_word_u  word_data_o,
    input  wire            word_ready_i
);
    localparam logic [1:0] LAST = 2'(`CAP_SAMPLES_PER_WORD - 1);

    logic [1:0] fill_cnt;  // samples already shifted in
    logic       pop;
    logic       keep;

    // a pending word blocks forwarding until the word FIFO takes it
    assign sample_ready_o = drain_i || (forward_en_i && (!word_valid_o || word_ready_i));
    assign pop            = sample_valid_i && sample_ready_o;
    assign keep           = pop && !drain_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            fill_cnt     <= 2'd0;
            word_valid_o <= 1'b0;
        end else begin
            if (word_valid_o && word_ready_i)
                word_valid_o <= 1'b0;
            if (keep) begin
                if (fill_cnt == LAST) begin
                    fill_cnt     <= 2'd0;
                    word_valid_o <= 1'b1;
                end else begin
                    fill_cnt <= fill_cnt + 2'd1;
                end
            end
        end
    end

    // shifting on the transfer edge is safe, the FIFO has captured the old word
    always_ff @(posedge adc_sampleclk) begin
        if (keep)
            word_data_o.samples <= {word_data_o.samples[`CAP_SAMPLES_PER_WORD-2:0], sample_data_i};
    end

endmodule

`default_nettype wire

//--- hw/byte_serializer.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module byte_serializer
    import capture_pkg::*;
(
    input  wire                adc_sampleclk,
    input  wire                reset,
    input  wire                word_valid_i,
    input  wire capture_word_u word_data_i,
    output logic               word_ready_o,
    input  wire                low_res_i,
    input  wire                low_res_lsb_i,
    input  wire                capture_done_i,
    output logic [7:0]         read_data_o,
    output logic               read_valid_o,
    input  wire                read_ready_i
);
    localparam logic [2:0] LOW_LAST = 3'(`CAP_SAMPLES_PER_WORD - 1);

    capture_word_u cur;         // word whose bytes are going out
    logic [3:0]    nib;         // tail of the first word of a hi-res pair
    logic [2:0]    idx;         // next byte of cur
    logic          busy;
    logic          pend;        // hi-res: waiting for the second word of a pair
    logic          cur_second;
    logic          out_free;
    logic          pop;
    logic          flush;
    capture_word_u emit_word;
    logic [2:0]    emit_idx;
    logic          emit_second;
    logic          emit_last;
    logic [7:0]    emit_byte;

    function automatic logic [7:0] pick_byte(
        input capture_word_u w,
        input logic [2:0]    k,
        input logic          second,
        input logic [3:0]    n
    );
        sample_t     s;
        logic [39:0] joined;
        joined = {n, w} << (8 * k);  // second word follows the saved nibble
        if (low_res_i) begin
            s = w.samples[2'd2 - k[1:0]];
            return low_res_lsb_i ? s[7:0] : s[`CAP_SAMPLE_W-1 -: 8];
        end else if (second) begin
            return joined[39:32];
        end else begin
            return w.hires.bytes[2'd3 - k[1:0]];
        end
    endfunction

    assign out_free     = !read_valid_o || read_ready_i;
    assign word_ready_o = out_free && !busy;
    assign pop          = word_ready_o && word_valid_i;
    // odd word count at the end of a capture, pad the last nibble
    assign flush        = out_free && !busy && !word_valid_i && pend && capture_done_i;

    assign emit_word   = busy ? cur : word_data_i;
    assign emit_idx    = busy ? idx : 3'd0;
    assign emit_second = busy ? cur_second : pend;
    assign emit_last   = low_res_i ? (emit_idx == LOW_LAST)
                                   : (emit_idx == (emit_second ? 3'd4 : 3'd3));
    assign emit_byte   = flush ? {nib, 4'h0} : pick_byte(emit_word, emit_idx, emit_second, nib);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            read_valid_o <= 1'b0;
            busy         <= 1'b0;
            pend         <= 1'b0;
            idx          <= 3'd0;
            cur_second   <= 1'b0;
        end else if (out_free) begin
            read_valid_o <= busy || pop || flush;
            if (busy || pop) begin
                busy       <= !emit_last;
                idx        <= emit_idx + 3'd1;
                cur_second <= emit_second;
                if (emit_last && !low_res_i)
                    pend <= !emit_second;  // first word done, partner still due
            end else if (flush) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (pop)
            cur <= word_data_i;
        if (out_free && (busy || pop || flush))
            read_data_o <= emit_byte;
        if (out_free && (busy || pop) && emit_last && !emit_second)
            nib <= emit_word.hires.nibble;
    end

endmodule

`default_nettype wire

//--- hw/capture_top.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module capture_top
    import capture_pkg::*;
(
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    input  wire sample_t           adc_datain_i,
    input  wire                    arm_i,
    input  wire                    trigger_i,
    input  wire [`CAP_COUNT_W-1:0] presample_i,
    input  wire [`CAP_COUNT_W-1:0] max_samples_i,
    input  wire [`CAP_DECIM_W-1:0] downsample_i,
    input  wire                    low_res_i,
    input  wire                    low_res_lsb_i,
    input  wire                    read_ready_i,
    output wire [7:0]              read_data_o,
    output wire                    read_valid_o,
    output wire                    capture_done_o,
    output wire [2:0]              error_stat_o
);
    // controller to sample FIFO
    wire           sample_wr;
    wire sample_t  sample_data;
    wire           sample_fifo_ready;
    // sample FIFO to packer
    wire           sample_fifo_valid;
    wire sample_t  sample_fifo_data;
    wire           sample_pop_ready;
    wire           drain;
    wire           forward_en;
    // packer to word FIFO to serializer
    wire           word_valid;
    wire capture_word_u word_data;
    wire           word_fifo_ready;
    wire           word_fifo_valid;
    wire capture_word_u word_fifo_data;
    wire           word_pop_ready;

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .arm_i               (arm_i),
        .trigger_i           (trigger_i),
        .presample_i         (presample_i),
        .max_samples_i       (max_samples_i),
        .downsample_i        (downsample_i),
        .adc_datain_i        (adc_datain_i),
        .sample_fifo_ready_i (sample_fifo_ready),
        .sample_fifo_valid_i (sample_fifo_valid),
        .sample_wr_o         (sample_wr),
        .sample_data_o       (sample_data),
        .drain_o             (drain),
        .forward_en_o        (forward_en),
        .capture_done_o      (capture_done_o),
        .error_stat_o        (error_stat_o)
    );

    sync_fifo #(
        .WIDTH (`CAP_SAMPLE_W),
        .DEPTH (`CAP_SAMPLE_FIFO_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_valid_i    (sample_wr),
        .wr_data_i     (sample_data),
        .wr_ready_o    (sample_fifo_ready),
        .rd_valid_o    (sample_fifo_valid),
        .rd_data_o     (sample_fifo_data),
        .rd_ready_i    (sample_pop_ready)
    );

    word_packer u_word_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .sample_valid_i (sample_fifo_valid),
        .sample_data_i  (sample_fifo_data),
        .sample_ready_o (sample_pop_ready),
        .drain_i        (drain),
        .forward_en_i   (forward_en),
        .word_valid_o   (word_valid),
        .word_data_o    (word_data),
        .word_ready_i   (word_fifo_ready)
    );

    sync_fifo #(
        .WIDTH (`CAP_SAMPLE_W * `CAP_SAMPLES_PER_WORD),
        .DEPTH (`CAP_WORD_FIFO_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_valid_i    (word_valid),
        .wr_data_i     (word_data),
        .wr_ready_o    (word_fifo_ready),
        .rd_valid_o    (word_fifo_valid),
        .rd_data_o     (word_fifo_data),
        .rd_ready_i    (word_pop_ready)
    );

    byte_serializer u_byte_serializer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .word_valid_i   (word_fifo_valid),
        .word_data_i    (word_fifo_data),
        .word_ready_o   (word_pop_ready),
        .low_res_i      (low_res_i),
        .low_res_lsb_i  (low_res_lsb_i),
        .capture_done_i (capture_done_o),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .read_ready_i   (read_ready_i)
    );

endmodule

`default_nettype wire

//--- test/capture_assert.sv
`timescale 1ns/10ps
`default_nettype none

module capture_assert (
    input wire       adc_sampleclk,
    input wire       reset,
    input wire       arm_i,
    input wire       read_ready_i,
    input wire [7:0] read_data_i,
    input wire       read_valid_i,
    input wire       capture_done_i,
    input wire [2:0] error_stat_i
);
    int failures = 0;  // failed assertions so far

    // offered byte held until taken
    stall_stable: assert property (@(posedge adc_sampleclk) disable iff (reset)
        read_valid_i && !read_ready_i |=> read_valid_i && $stable(read_data_i))
        else begin
            failures++;
            $error("read_data_o or read_valid_o changed while read_ready_i was low");
        end

    idle_after_reset: assert property (@(posedge adc_sampleclk)
        reset |=> !read_valid_i && !capture_done_i && (error_stat_i == 3'b000))
        else begin
            failures++;
            $error("read_valid_o, capture_done_o or error_stat_o not cleared by reset");
        end

    // done is sticky until the next arm
    done_held: assert property (@(posedge adc_sampleclk) disable iff (reset)
        capture_done_i && !arm_i |=> capture_done_i)
        else begin
            failures++;
            $error("capture_done_o fell without arm_i");
        end

endmodule

bind capture_top capture_assert u_capture_assert (
    .adc_sampleclk  (adc_sampleclk),
    .reset          (reset),
    .arm_i          (arm_i),
    .read_ready_i   (read_ready_i),
    .read_data_i    (read_data_o),
    .read_valid_i   (read_valid_o),
    .capture_done_i (capture_done_o),
    .error_stat_i   (error_stat_o)
);

`default_nettype wire

//--- test/capture_checker.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module capture_checker
    import capture_pkg::*;
(
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    input  wire                    arm_i,
    input  wire [7:0]              read_data_i,
    input  wire                    read_valid_i,
    input  wire                    read_ready_i,
    input  wire                    capture_done_i,
    input  wire [2:0]              error_stat_i,
    input  wire [`CAP_COUNT_W-1:0] max_samples_i,
    input  wire [`CAP_DECIM_W-1:0] downsample_i,
    input  wire                    low_res_i,
    input  wire                    low_res_lsb_i,
    input  wire [2:0]              exp_err_i,
    input  wire                    check_ramp_i,
    input  wire                    case_end_i,
    input  wire [7:0]              case_num_i,
    output int                     exp_bytes_o,
    output int                     byte_count_o,
    output int                     case_count_o,
    output int                     fail_count_o
);
    logic [7:0]  got_bytes [$];
    logic [11:0] got_samples [$];
    int          exp_samples;
    logic        after_reset = 1'b0;

    // whole words of three samples, hi-res packs 12 bits per sample
    assign exp_samples = ((max_samples_i + 2) / 3) * 3;
    assign exp_bytes_o = low_res_i ? exp_samples : (exp_samples * 12 + 7) / 8;

    task automatic check_case();
        int          errs;
        int          step;
        int          k;
        int          i;
        int          b;
        int          pad_bits;
        logic [7:0]  lo_d;
        logic [7:0]  hi_d;
        logic [7:0]  diff;
        logic [7:0]  pad_mask;
        logic [7:0]  last;
        logic [11:0] smp;
        logic [11:0] want;
        logic        ramp_ok;
        errs    = 0;
        ramp_ok = 1'b1;
        step    = int'(downsample_i) + 1;
        if (got_bytes.size() != exp_bytes_o) begin
            $display("** Error case %0d: read_data_o byte count got 0x%0h expected 0x%0h",
                     case_num_i, got_bytes.size(), exp_bytes_o);
            errs++;
        end
        if (error_stat_i !== exp_err_i) begin
            $display("** Error case %0d: error_stat_o got 0x%0h expected 0x%0h",
                     case_num_i, error_stat_i, exp_err_i);
            errs++;
        end
        if (check_ramp_i && (got_bytes.size() == exp_bytes_o)) begin
            if (low_res_i) begin
                lo_d = low_res_lsb_i ? 8'(step) : 8'(step / 16);  // upper bits step unevenly
                hi_d = low_res_lsb_i ? 8'(step) : 8'((step + 15) / 16);
                for (k = 1; k < got_bytes.size() && ramp_ok; k++) begin
                    diff = got_bytes[k] - got_bytes[k-1];
                    if (diff < lo_d || diff > hi_d) begin
                        $display("** Error case %0d: read_data_o byte %0d got 0x%02h",
                                 case_num_i, k, got_bytes[k],
                                 " expected 0x%02h to 0x%02h",
                                 got_bytes[k-1] + lo_d, got_bytes[k-1] + hi_d);
                        ramp_ok = 1'b0;
                        errs++;
                    end
                end
            end else begin
                got_samples.delete();
                for (k = 0; k < exp_samples; k++) begin
                    for (i = 0; i < 12; i++) begin
                        b = k * 12 + i;
                        smp[11 - i] = got_bytes[b / 8][7 - b % 8];  // msb first
                    end
                    got_samples.push_back(smp);
                end
                for (k = 1; k < exp_samples && ramp_ok; k++) begin
                    want = got_samples[k-1] + 12'(step);
                    if (got_samples[k] != want) begin
                        $display("** Error case %0d: read_data_o sample %0d got 0x%03h",
                                 case_num_i, k, got_samples[k],
                                 " expected 0x%03h", want);
                        ramp_ok = 1'b0;
                        errs++;
                    end
                end
                pad_bits = exp_bytes_o * 8 - exp_samples * 12;
                pad_mask = 8'((1 << pad_bits) - 1);
                last     = got_bytes[exp_bytes_o - 1];
                if ((last & pad_mask) != 8'h00) begin
                    $display("** Error case %0d: read_data_o last byte got 0x%02h",
                             case_num_i, last, " expected 0x%02h", last & ~pad_mask);
                    errs++;
                end
            end
        end
        if (errs == 0)
            $display("case %0d ok: %0d bytes, overflow %0b, early trigger %0b, config %0b",
                     case_num_i, got_bytes.size(), error_stat_i[err_overflow_bit],
                     error_stat_i[err_presamp_bit], error_stat_i[err_config_bit]);
        else
            $display("case %0d bad: %0d mismatches", case_num_i, errs);
        case_count_o++;
        if (errs != 0)
            fail_count_o++;
    endtask

    always @(posedge adc_sampleclk) begin
        if (reset) begin
            after_reset <= 1'b1;
        end else if (after_reset) begin
            after_reset <= 1'b0;
            if (read_valid_i || capture_done_i || (error_stat_i != 3'b000)) begin
                $display("** Error after reset: read_valid_o 0x%0h capture_done_o 0x%0h",
                         read_valid_i, capture_done_i,
                         " error_stat_o 0x%0h expected 0x0", error_stat_i);
                fail_count_o++;
            end
        end
        if (arm_i)
            got_bytes.delete();  // new capture
        else if (read_valid_i && read_ready_i)
            got_bytes.push_back(read_data_i);
        byte_count_o <= got_bytes.size();
        if (case_end_i)
            check_case();
    end

endmodule

`default_nettype wire

//--- test/capture_tb.sv
`include "capture_config.svh"
`timescale 1ns/10ps
`default_nettype none

module capture_tb;
    localparam int FIELDS       = 8;  // words per pattern line
    localparam int MAX_CASES    = 16;
    localparam int DONE_TIMEOUT = 6000;
    localparam int BYTE_TIMEOUT = 3000;
    localparam int STALL_CYCLES = 300;

    logic                     adc_sampleclk;
    logic                     reset;
    logic [`CAP_SAMPLE_W-1:0] adc_data;
    logic                     arm;
    logic                     trigger;
    logic [`CAP_COUNT_W-1:0]  presample;
    logic [`CAP_COUNT_W-1:0]  max_samples;
    logic [`CAP_DECIM_W-1:0]  downsample;
    logic                     low_res;
    logic                     low_res_lsb;
    logic                     read_ready;
    wire  [7:0]               read_data;
    wire                      read_valid;
    wire                      capture_done;
    wire  [2:0]               error_stat;

    logic [15:0] pattern_mem [FIELDS*MAX_CASES];
    logic [1:0]  bp_mode;
    logic [2:0]  exp_err;
    logic        check_ramp;
    logic        case_end;
    logic [7:0]  case_num;
    int          exp_bytes;
    int          byte_count;
    int          case_count;
    int          fail_count;
    int          stall_cnt;
    int          idx;

    capture_top u_capture_top (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_datain_i   (adc_data),
        .arm_i          (arm),
        .trigger_i      (trigger),
        .presample_i    (presample),
        .max_samples_i  (max_samples),
        .downsample_i   (downsample),
        .low_res_i      (low_res),
        .low_res_lsb_i  (low_res_lsb),
        .read_ready_i   (read_ready),
        .read_data_o    (read_data),
        .read_valid_o   (read_valid),
        .capture_done_o (capture_done),
        .error_stat_o   (error_stat)
    );

    capture_checker u_capture_checker (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .arm_i          (arm),
        .read_data_i    (read_data),
        .read_valid_i   (read_valid),
        .read_ready_i   (read_ready),
        .capture_done_i (capture_done),
        .error_stat_i   (error_stat),
        .max_samples_i  (max_samples),
        .downsample_i   (downsample),
        .low_res_i      (low_res),
        .low_res_lsb_i  (low_res_lsb),
        .exp_err_i      (exp_err),
        .check_ramp_i   (check_ramp),
        .case_end_i     (case_end),
        .case_num_i     (case_num),
        .exp_bytes_o    (exp_bytes),
        .byte_count_o   (byte_count),
        .case_count_o   (case_count),
        .fail_count_o   (fail_count)
    );

    initial adc_sampleclk = 1'b0;
    always #4 adc_sampleclk = ~adc_sampleclk;

    // ramp input and reader back-pressure
    always @(posedge adc_sampleclk) begin
        adc_data  <= adc_data + 1'b1;
        stall_cnt <= arm ? 0 : stall_cnt + 1;
        case (bp_mode)
            2'd1:    read_ready <= ($urandom % 4) != 0;
            2'd2:    read_ready <= (stall_cnt >= STALL_CYCLES);  // long stall after arm
            default: read_ready <= 1'b1;
        endcase
    end

    task automatic run_case(input int n);
        int base;
        int delay;
        int waited;
        base  = n * FIELDS;
        delay = int'(pattern_mem[base + 5]);
        @(posedge adc_sampleclk);
        presample   <= pattern_mem[base];
        max_samples <= pattern_mem[base + 1];
        downsample  <= pattern_mem[base + 2][`CAP_DECIM_W-1:0];
        low_res     <= pattern_mem[base + 3][0];
        low_res_lsb <= pattern_mem[base + 4][0];
        bp_mode     <= pattern_mem[base + 6][1:0];
        exp_err     <= pattern_mem[base + 7][2:0];
        check_ramp  <= !pattern_mem[base + 7][0];  // dropped samples break the ramp
        case_num    <= 8'(n + 1);
        @(posedge adc_sampleclk);
        arm <= 1'b1;
        @(posedge adc_sampleclk);
        arm <= 1'b0;
        repeat (delay) @(posedge adc_sampleclk);
        trigger <= 1'b1;
        @(posedge adc_sampleclk);
        trigger <= 1'b0;
        waited = 0;
        while (!capture_done && waited < DONE_TIMEOUT) begin
            @(posedge adc_sampleclk);
            waited++;
        end
        if (!capture_done) begin
            $display("case %0d: capture_done_o did not rise in time", n + 1);
            $display("test failed");
            $finish;
        end
        waited = 0;
        while (byte_count < exp_bytes && waited < BYTE_TIMEOUT) begin
            @(posedge adc_sampleclk);
            waited++;
        end
        if (byte_count < exp_bytes) begin
            $display("case %0d: only %0d of %0d bytes arrived", n + 1, byte_count, exp_bytes);
            $display("test failed");
            $finish;
        end
        repeat (16) @(posedge adc_sampleclk);  // catch surplus bytes
        case_end <= 1'b1;
        @(posedge adc_sampleclk);
        case_end <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'hd96b920f));
        reset       = 1'b1;
        adc_data    = '0;
        arm         = 1'b0;
        trigger     = 1'b0;
        presample   = '0;
        max_samples = '0;
        downsample  = '0;
        low_res     = 1'b0;
        low_res_lsb = 1'b0;
        read_ready  = 1'b0;
        bp_mode     = 2'd0;
        exp_err     = 3'b000;
        check_ramp  = 1'b0;
        case_end    = 1'b0;
        case_num    = 8'd0;
        stall_cnt   = 0;
        idx         = 0;
        for (int m = 0; m < FIELDS * MAX_CASES; m++)
            pattern_mem[m] = '0;
        $readmemh("test/capture_patterns.txt", pattern_mem);
        repeat (4) @(posedge adc_sampleclk);
        reset <= 1'b0;
        repeat (2) @(posedge adc_sampleclk);
        // unused lines stay zero, every real case has a nonzero max_samples
        while (idx < MAX_CASES && pattern_mem[idx * FIELDS + 1] != '0) begin
            run_case(idx);
            idx++;
        end
        @(posedge adc_sampleclk);
        $display("cases %0d, failing %0d, assertion failures %0d",
                 case_count, fail_count, u_capture_top.u_capture_assert.failures);
        if (case_count == 0 || fail_count != 0 ||
            u_capture_top.u_capture_assert.failures != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/capture_pkg.sv
hw/sync_fifo.sv
hw/capture_ctrl.sv
hw/word_packer.sv
hw/byte_serializer.sv
hw/capture_top.sv
test/capture_assert.sv
test/capture_checker.sv
test/capture_tb.sv

//--- test/capture_patterns.txt
// presample max_samples downsample low_res lsb trigger_delay backpressure exp_err, all hex
// backpressure 0 none, 1 random gaps, 2 long stall; exp_err bit 0 overflow, 1 early, 2 config
0000 000a 00 1 0 04 0 0
0000 001b 00 0 0 04 0 0
0000 0040 02 0 0 04 0 0
0000 0020 03 1 1 04 0 0
0010 0030 00 1 1 40 0 0
0010 0030 00 1 0 05 0 2
0008 0024 02 1 1 60 0 4
0000 002a 00 1 1 04 1 0
0000 0015 01 0 0 04 1 0
0000 00c0 00 1 1 04 2 1
